// ==== include/memAxi_consts.svh ====
// bus widths are fixed at 32-bit data, 4-bit IDs and AXI4 8-bit lengths; memory keeps 12 bits
`ifndef MEM_AXI_CONSTS_SVH
`define MEM_AXI_CONSTS_SVH

// ------------------------------
// AXI4 bus
// ------------------------------
`define AXI_ID_W   4    // transaction id
`define AXI_ADDR_W 32   // full bus address
`define AXI_DATA_W 32
`define AXI_STRB_W 4    // one strobe per data byte
`define AXI_LEN_W  8    // AXI4 only, no AXI3 length

// memory side, 4 KiB aliased over the bus address space
`define MEM_ADDR_W 12   // byte address bits kept
`define MEM_OFFS_W 2    // byte offset inside a word

`endif

// ==== logic/axiProtoPkg.sv ====
// AXI4 types only; WRAP and reserved burst codes advance like FIXED, sizes above the bus step by word
`default_nettype none
`include "memAxi_consts.svh"

package axiProtoPkg;

  typedef logic [`AXI_ID_W-1:0]  axiIdT;
  typedef logic [`AXI_LEN_W-1:0] axiLenT;   // beats minus one
  typedef logic [2:0]            axiSizeT;  // log2 of bytes per beat

  typedef enum logic [1:0] {FIXED = 2'b00, INCR = 2'b01, WRAP = 2'b10, RSVD = 2'b11} axiBurstT;
  typedef enum logic [1:0] {OKAY = 2'b00, EXOKAY = 2'b01, SLVERR = 2'b10, DECERR = 2'b11} axiRespT;

  // address of the following beat inside a burst
  function automatic logic [`MEM_ADDR_W-1:0] nextBurstAddr(
    input logic [`MEM_ADDR_W-1:0] addr,
    input axiSizeT                size,
    input axiBurstT               burst
  );
    logic [`MEM_ADDR_W-1:0] step;
    step = 1;
    step = step << size;
    if (burst != INCR) begin
      nextBurstAddr = addr;                                  // FIXED, WRAP and RSVD
    end else if (size < `MEM_OFFS_W) begin
      nextBurstAddr = addr + step;                           // narrow beat
    end else begin
      nextBurstAddr = {addr[`MEM_ADDR_W-1:`MEM_OFFS_W] + 1'b1, {`MEM_OFFS_W{1'b0}}};
    end
  endfunction

endpackage

`default_nettype wire

// ==== logic/memTypesPkg.sv ====
// memory-side types for a 4 KiB word-organised RAM; state enums of both channel controllers
`default_nettype none
`include "memAxi_consts.svh"

package memTypesPkg;

  typedef logic [`MEM_ADDR_W-1:0] memAddrT;   // byte address
  typedef logic [`AXI_DATA_W-1:0] memDataT;
  typedef logic [`AXI_STRB_W-1:0] memStrbT;

  // ------------------------------
  // controller states
  // ------------------------------
  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wrStateT;
  typedef enum logic [1:0] {RD_IDLE, RD_FETCH, RD_SEND} rdStateT;

endpackage

`default_nettype wire

// ==== logic/memWriteIf.sv ====
// one RAM write per cycle with no handshake; the write lands at the edge where wrEn is high
`default_nettype none

interface memWriteIf;
  import memTypesPkg::*;

  logic    wrEn;
  memAddrT wrAddr;   // byte address, low bits ignored by the RAM
  memDataT wrData;
  memStrbT wrStrb;   // byte enables

  modport ctrl (output wrEn, wrAddr, wrData, wrStrb);
  modport ram  (input wrEn, wrAddr, wrData, wrStrb);

endinterface

`default_nettype wire

// ==== logic/axiWriteCtrl.sv ====
// one write burst at a time, no WID so no id check; SLVERR only flags a missing WLAST
`default_nettype none
`include "memAxi_consts.svh"

module axiWriteCtrl (
  input  logic                   ACLK,
  input  logic                   ARESETn,
  input  axiProtoPkg::axiIdT     AWID,
  input  logic [`AXI_ADDR_W-1:0] AWADDR,
  input  axiProtoPkg::axiLenT    AWLEN,
  input  axiProtoPkg::axiSizeT   AWSIZE,
  input  axiProtoPkg::axiBurstT  AWBURST,
  input  logic                   AWVALID,
  output logic                   AWREADY,
  input  logic [`AXI_DATA_W-1:0] WDATA,
  input  logic [`AXI_STRB_W-1:0] WSTRB,
  input  logic                   WLAST,
  input  logic                   WVALID,
  output logic                   WREADY,
  output axiProtoPkg::axiIdT     BID,
  output axiProtoPkg::axiRespT   BRESP,
  output logic                   BVALID,
  input  logic                   BREADY,
  memWriteIf.ctrl                memWr
);
  import axiProtoPkg::*;
  import memTypesPkg::*;

  wrStateT  state;
  axiIdT    awId;
  memAddrT  addr;      // address of the next beat
  axiLenT   len;
  axiSizeT  size;
  axiBurstT burst;
  axiLenT   beatCnt;   // beats accepted so far
  logic     awFire;
  logic     wFire;
  logic     lastBeat;

  assign awFire   = AWVALID && AWREADY;
  assign wFire    = WVALID && WREADY;
  assign lastBeat = (beatCnt == len);

  // ------------------------------
  // control FSM
  // ------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state      <= WR_IDLE;
      AWREADY    <= 1'b0;
      WREADY     <= 1'b0;
      BVALID     <= 1'b0;
      beatCnt    <= '0;
      memWr.wrEn <= 1'b0;
    end else begin
      memWr.wrEn <= 1'b0;                        // single-cycle pulse per beat
      case (state)
        WR_IDLE: begin
          if (awFire) begin
            AWREADY <= 1'b0;
            WREADY  <= 1'b1;
            beatCnt <= '0;
            state   <= WR_DATA;
          end else begin
            AWREADY <= 1'b1;
          end
        end
        WR_DATA: begin
          if (wFire) begin
            memWr.wrEn <= 1'b1;
            beatCnt    <= beatCnt + 1'b1;
            if (lastBeat) begin
              WREADY <= 1'b0;
              BVALID <= 1'b1;
              state  <= WR_RESP;
            end
          end
        end
        WR_RESP: begin
          if (BREADY) begin
            BVALID  <= 1'b0;
            AWREADY <= 1'b1;
            state   <= WR_IDLE;
          end
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  // burst attributes and beat payload
  always_ff @(posedge ACLK) begin
    if (awFire) begin
      awId  <= AWID;
      addr  <= AWADDR[`MEM_ADDR_W-1:0];          // upper bits alias
      len   <= AWLEN;
      size  <= AWSIZE;
      burst <= AWBURST;
    end
    if (wFire) begin
      memWr.wrAddr <= addr;
      memWr.wrData <= WDATA;
      memWr.wrStrb <= WSTRB;
      addr         <= nextBurstAddr(addr, size, burst);
      if (lastBeat) begin
        BID <= awId;
        if (WLAST) begin
          BRESP <= OKAY;
        end else begin
          BRESP <= SLVERR;                       // final beat without WLAST
        end
      end
    end
  end

  // response must survive back-pressure unchanged
  bRespHeld: assert property (@(posedge ACLK) disable iff (!ARESETn)
    BVALID && !BREADY |=> BVALID && $stable(BID));

endmodule

`default_nettype wire

// ==== logic/axiReadCtrl.sv ====
// one read in flight; each beat is fetched only after the previous beat is taken, RRESP is OKAY
`default_nettype none
`include "memAxi_consts.svh"

module axiReadCtrl (
  input  logic                     ACLK,
  input  logic                     ARESETn,
  input  axiProtoPkg::axiIdT       ARID,
  input  logic [`AXI_ADDR_W-1:0]   ARADDR,
  input  axiProtoPkg::axiLenT      ARLEN,
  input  axiProtoPkg::axiSizeT     ARSIZE,
  input  axiProtoPkg::axiBurstT    ARBURST,
  input  logic                     ARVALID,
  output logic                     ARREADY,
  output axiProtoPkg::axiIdT       RID,
  output logic [`AXI_DATA_W-1:0]   RDATA,
  output axiProtoPkg::axiRespT     RRESP,
  output logic                     RLAST,
  output logic                     RVALID,
  input  logic                     RREADY,
  output logic                     rdEn,
  output memTypesPkg::memAddrT     rdAddr,
  input  memTypesPkg::memDataT     rdData
);
  import axiProtoPkg::*;
  import memTypesPkg::*;

  rdStateT  state;
  memAddrT  addr;      // address of the beat being fetched
  axiLenT   len;
  axiSizeT  size;
  axiBurstT burst;
  axiLenT   beatCnt;   // index of the current beat
  logic     arFire;
  logic     rFire;

  assign arFire = ARVALID && ARREADY;
  assign rFire  = RVALID && RREADY;

  assign rdEn   = (state == RD_FETCH);         // RAM answers next cycle
  assign rdAddr = addr;
  assign RRESP  = OKAY;

  // ------------------------------
  // control FSM
  // ------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state   <= RD_IDLE;
      ARREADY <= 1'b0;
      RVALID  <= 1'b0;
      RLAST   <= 1'b0;
      beatCnt <= '0;
    end else begin
      case (state)
        RD_IDLE: begin
          if (arFire) begin
            ARREADY <= 1'b0;
            beatCnt <= '0;
            state   <= RD_FETCH;
          end else begin
            ARREADY <= 1'b1;
          end
        end
        RD_FETCH: state <= RD_SEND;
        RD_SEND: begin
          if (!RVALID) begin
            RVALID <= 1'b1;                    // rdData is valid now
            RLAST  <= (beatCnt == len);
          end else if (RREADY) begin
            RVALID <= 1'b0;
            RLAST  <= 1'b0;
            if (RLAST) begin
              ARREADY <= 1'b1;
              state   <= RD_IDLE;
            end else begin
              beatCnt <= beatCnt + 1'b1;
              state   <= RD_FETCH;
            end
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  // burst attributes and returned data
  always_ff @(posedge ACLK) begin
    if (arFire) begin
      RID   <= ARID;
      addr  <= ARADDR[`MEM_ADDR_W-1:0];
      len   <= ARLEN;
      size  <= ARSIZE;
      burst <= ARBURST;
    end
    if (state == RD_SEND && !RVALID) begin
      RDATA <= rdData;                         // full word, master picks lanes
    end
    if (rFire && !RLAST) begin
      addr <= nextBurstAddr(addr, size, burst);
    end
  end

  // a stalled beat keeps its payload until taken
  rBeatHeld: assert property (@(posedge ACLK) disable iff (!ARESETn)
    RVALID && !RREADY |=> RVALID && $stable(RDATA) && $stable(RLAST));

endmodule

`default_nettype wire

// ==== logic/memDualPortRam.sv ====
// 1024 x 32 RAM, one write and one read port, no reset of contents; same-word read sees new bytes
`default_nettype none
`include "memAxi_consts.svh"

module memDualPortRam (
  input  logic                 ACLK,
  memWriteIf.ram               memWr,
  input  logic                 rdEn,
  input  memTypesPkg::memAddrT rdAddr,
  output memTypesPkg::memDataT rdData
);
  import memTypesPkg::*;

  localparam int memDepth = 1 << (`MEM_ADDR_W - `MEM_OFFS_W);

  memDataT                            mem [memDepth];
  logic [`MEM_ADDR_W-`MEM_OFFS_W-1:0] wrWord;
  logic [`MEM_ADDR_W-`MEM_OFFS_W-1:0] rdWord;
  memDataT                            rdMerged;   // stored word with bypassed bytes

  assign wrWord = memWr.wrAddr[`MEM_ADDR_W-1:`MEM_OFFS_W];
  assign rdWord = rdAddr[`MEM_ADDR_W-1:`MEM_OFFS_W];

  // write-first bypass
  always_comb begin
    rdMerged = mem[rdWord];
    if (memWr.wrEn && (wrWord == rdWord)) begin
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        if (memWr.wrStrb[b]) rdMerged[8*b +: 8] = memWr.wrData[8*b +: 8];
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (memWr.wrEn) begin
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        if (memWr.wrStrb[b]) mem[wrWord][8*b +: 8] <= memWr.wrData[8*b +: 8];
      end
    end
    if (rdEn) rdData <= rdMerged;             // holds between fetches
  end

  // write controller never issues a write to an unknown address
  wrAddrKnown: assert property (@(posedge ACLK) memWr.wrEn |-> !$isunknown(memWr.wrAddr));

endmodule

`default_nettype wire

// ==== logic/memAxiTop.sv ====
// AXI4 slave of 4 KiB, aliased above bit 11; no WRAP, no sideband or low-power pins, no extra latency
`default_nettype none
`include "memAxi_consts.svh"

module memAxiTop (
  input  logic                   ACLK,
  input  logic                   ARESETn,
  // ------------------------------
  // write channels
  // ------------------------------
  input  axiProtoPkg::axiIdT     AWID,
  input  logic [`AXI_ADDR_W-1:0] AWADDR,
  input  axiProtoPkg::axiLenT    AWLEN,
  input  axiProtoPkg::axiSizeT   AWSIZE,
  input  axiProtoPkg::axiBurstT  AWBURST,
  input  logic                   AWVALID,
  output logic                   AWREADY,
  input  logic [`AXI_DATA_W-1:0] WDATA,
  input  logic [`AXI_STRB_W-1:0] WSTRB,
  input  logic                   WLAST,
  input  logic                   WVALID,
  output logic                   WREADY,
  output axiProtoPkg::axiIdT     BID,
  output axiProtoPkg::axiRespT   BRESP,
  output logic                   BVALID,
  input  logic                   BREADY,
  // ------------------------------
  // read channels
  // ------------------------------
  input  axiProtoPkg::axiIdT     ARID,
  input  logic [`AXI_ADDR_W-1:0] ARADDR,
  input  axiProtoPkg::axiLenT    ARLEN,
  input  axiProtoPkg::axiSizeT   ARSIZE,
  input  axiProtoPkg::axiBurstT  ARBURST,
  input  logic                   ARVALID,
  output logic                   ARREADY,
  output axiProtoPkg::axiIdT     RID,
  output logic [`AXI_DATA_W-1:0] RDATA,
  output axiProtoPkg::axiRespT   RRESP,
  output logic                   RLAST,
  output logic                   RVALID,
  input  logic                   RREADY
);
  import memTypesPkg::*;

  memWriteIf memWr();   // write port into the RAM
  logic      rdEn;
  memAddrT   rdAddr;
  memDataT   rdData;

  axiWriteCtrl writeCtrl (.*);     // AW, W, B

  axiReadCtrl readCtrl (.*);       // AR, R

  memDualPortRam dpRam (
    .ACLK   (ACLK),
    .memWr  (memWr),
    .rdEn   (rdEn),
    .rdAddr (rdAddr),
    .rdData (rdData)
  );

endmodule

`default_nettype wire

// ==== testbench/tbMemAxi.sv ====
// run from the project root; one transaction at a time, and only bytes already written are compared
`default_nettype none
`include "memAxi_consts.svh"

module tbMemAxi;
  import axiProtoPkg::*;

  // ------------------------------
  // DUT signals
  // ------------------------------
  logic                   ACLK;
  logic                   ARESETn;
  axiIdT                  AWID;
  logic [`AXI_ADDR_W-1:0] AWADDR;
  axiLenT                 AWLEN;
  axiSizeT                AWSIZE;
  axiBurstT               AWBURST;
  logic                   AWVALID;
  logic                   AWREADY;
  logic [`AXI_DATA_W-1:0] WDATA;
  logic [`AXI_STRB_W-1:0] WSTRB;
  logic                   WLAST;
  logic                   WVALID;
  logic                   WREADY;
  axiIdT                  BID;
  axiRespT                BRESP;
  logic                   BVALID;
  logic                   BREADY;
  axiIdT                  ARID;
  logic [`AXI_ADDR_W-1:0] ARADDR;
  axiLenT                 ARLEN;
  axiSizeT                ARSIZE;
  axiBurstT               ARBURST;
  logic                   ARVALID;
  logic                   ARREADY;
  axiIdT                  RID;
  logic [`AXI_DATA_W-1:0] RDATA;
  axiRespT                RRESP;
  logic                   RLAST;
  logic                   RVALID;
  logic                   RREADY;

  // records from the stimulus file
  logic                   recWrite [$];
  axiIdT                  recId    [$];
  logic [`AXI_ADDR_W-1:0] recAddr  [$];
  axiLenT                 recLen   [$];
  axiSizeT                recSize  [$];
  logic [1:0]             recBurst [$];
  logic                   recDrop  [$];   // WLAST left low on the final beat
  logic [1:0]             recResp  [$];
  logic [`AXI_DATA_W-1:0] beatData [$];
  logic [`AXI_STRB_W-1:0] beatStrb [$];

  logic [7:0] refMem   [1 << `MEM_ADDR_W];   // byte-wide reference memory
  logic       refKnown [1 << `MEM_ADDR_W];   // byte written at least once

  int          checks = 0;
  int          errors = 0;
  int          testErrors = 0;
  int          cycles = 0;
  int          cycleLimit = 200;
  logic [31:0] lfsr = 32'h6a40a1bc;

  memAxiTop dut_i (.*);

  always #4 ACLK = ~ACLK;

  // run limit
  always @(posedge ACLK) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Checks failed");
      $finish;
    end
  end

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic nextCycle();
    @(posedge ACLK);
    #1;                                        // drive and sample point
  endtask

  // Galois LFSR over x^32+x^22+x^2+x+1 giving one random bit
  task automatic takeBit(output logic b);
    b = lfsr[0];
    lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
  endtask

  task automatic reportMismatch(input int t, input string msg);
    errors++;
    testErrors++;
    $display("[FAIL] t=%0t test %0d: %s", $time, t + 1, msg);
  endtask

  // FIXED keeps the address, narrow INCR adds the size, full INCR goes to the next word
  function automatic logic [`MEM_ADDR_W-1:0] advanceAddr(input logic [`MEM_ADDR_W-1:0] a,
                                                         input logic [2:0] size,
                                                         input logic [1:0] burst);
    logic [`MEM_ADDR_W-1:0] next;
    if (burst != 2'b01) begin
      next = a;                                // WRAP and reserved too
    end else if (size < 3'd2) begin
      next = a + ((size == 3'd0) ? 12'd1 : 12'd2);
    end else begin
      next = (a | 12'h003) + 12'd1;            // first byte of the following word
    end
    return next;
  endfunction

  task automatic storeBeat(input logic [`MEM_ADDR_W-1:0] a, input logic [`AXI_DATA_W-1:0] data,
                           input logic [`AXI_STRB_W-1:0] strb);
    logic [`MEM_ADDR_W-1:0] base;
    base = {a[`MEM_ADDR_W-1:`MEM_OFFS_W], {`MEM_OFFS_W{1'b0}}};
    for (int b = 0; b < `AXI_STRB_W; b++) begin
      if (strb[b]) begin
        refMem[base + b]   = data[8*b +: 8];
        refKnown[base + b] = 1'b1;
      end
    end
  endtask

  task automatic checkWord(input int t, input int beat, input logic [`MEM_ADDR_W-1:0] a,
                           input logic [`AXI_DATA_W-1:0] got);
    logic [`MEM_ADDR_W-1:0] base;
    logic [`AXI_DATA_W-1:0] want;
    logic [`AXI_DATA_W-1:0] mask;
    base = {a[`MEM_ADDR_W-1:`MEM_OFFS_W], {`MEM_OFFS_W{1'b0}}};
    want = '0;
    mask = '0;
    for (int b = 0; b < `AXI_STRB_W; b++) begin
      if (refKnown[base + b]) begin
        want[8*b +: 8] = refMem[base + b];
        mask[8*b +: 8] = 8'hff;
      end
    end
    checks++;
    if ((got & mask) !== want) begin
      reportMismatch(t, $sformatf("RDATA %h on beat %0d, expected %h under mask %h",
                                  got, beat, want, mask));
    end
  endtask

  // ------------------------------
  // stimulus file
  // ------------------------------
  task automatic loadStimulus(output logic ok);
    int                     fd;
    int                     n;
    int                     beatsDue;
    int                     beatTotal;
    string                  line;
    logic [7:0]             kind;
    axiIdT                  id;
    logic [`AXI_ADDR_W-1:0] addr;
    axiLenT                 len;
    axiSizeT                size;
    logic [1:0]             burst;
    logic                   drop;
    logic [1:0]             resp;
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
    ok = 1'b1;
    beatsDue = 0;
    beatTotal = 0;
    fd = $fopen("testbench/memAxi_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/memAxi_stimulus.txt");
      ok = 1'b0;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          if (beatsDue > 0) begin
            n = $sscanf(line, "%h %h", data, strb);
            if (n != 2) ok = 1'b0;
            beatData.push_back(data);
            beatStrb.push_back(strb);
            beatsDue--;
          end else begin
            n = $sscanf(line, "%c %h %h %h %h %h %h %h",
                        kind, id, addr, len, size, burst, drop, resp);
            if (n != 8 || (kind != "W" && kind != "R")) begin
              ok = 1'b0;
            end else begin
              recWrite.push_back(kind == "W");
              recId.push_back(id);
              recAddr.push_back(addr);
              recLen.push_back(len);
              recSize.push_back(size);
              recBurst.push_back(burst);
              recDrop.push_back(drop);
              recResp.push_back(resp);
              if (kind == "W") beatsDue = len + 1;
              beatTotal += len + 1;
            end
          end
        end
      end
      $fclose(fd);
      if (beatsDue != 0 || recWrite.size() == 0) ok = 1'b0;
      if (!ok) $display("the stimulus file is malformed or empty");
      cycleLimit = 40 * beatTotal + 200;
    end
  endtask

  // ------------------------------
  // bus transactions
  // ------------------------------
  task automatic runWrite(input int t, inout int beatPos);
    logic [`MEM_ADDR_W-1:0] a;
    logic                   gap;
    logic                   hs;
    AWID    = recId[t];
    AWADDR  = recAddr[t];
    AWLEN   = recLen[t];
    AWSIZE  = recSize[t];
    AWBURST = axiBurstT'(recBurst[t]);
    AWVALID = 1'b1;
    hs = 1'b0;
    while (!hs) begin
      hs = AWREADY;
      nextCycle();
    end
    AWVALID = 1'b0;
    checks++;
    if (AWREADY) reportMismatch(t, "AWREADY still high after the AW handshake");
    a = recAddr[t][`MEM_ADDR_W-1:0];           // upper bits alias
    for (int beat = 0; beat <= recLen[t]; beat++) begin
      takeBit(gap);
      if (gap) begin
        WVALID = 1'b0;                         // idle cycle on W
        nextCycle();
      end
      WDATA  = beatData[beatPos];
      WSTRB  = beatStrb[beatPos];
      WLAST  = (beat == recLen[t]) && !recDrop[t];
      WVALID = 1'b1;
      hs = 1'b0;
      while (!hs) begin
        hs = WREADY;
        nextCycle();
      end
      storeBeat(a, WDATA, WSTRB);
      a = advanceAddr(a, recSize[t], recBurst[t]);
      beatPos++;
    end
    WVALID = 1'b0;
    WLAST  = 1'b0;
    checks++;
    if (WREADY || !BVALID) begin
      reportMismatch(t, $sformatf("WREADY %b BVALID %b after the final W beat",
                                  WREADY, BVALID));
    end
    hs = 1'b0;
    while (!hs) begin
      takeBit(gap);
      BREADY = !gap;
      if (BVALID) begin
        checks++;
        if (BID !== recId[t] || BRESP !== recResp[t]) begin
          reportMismatch(t, $sformatf("BID %h BRESP %0d, expected %h %0d",
                                      BID, BRESP, recId[t], recResp[t]));
        end
      end
      hs = BVALID && BREADY;
      nextCycle();
    end
    BREADY = 1'b0;
  endtask

  task automatic runRead(input int t);
    logic [`MEM_ADDR_W-1:0] a;
    logic                   stall;
    logic                   hs;
    logic                   done;
    logic                   heldValid;
    logic [`AXI_DATA_W-1:0] heldData;
    logic                   heldLast;
    int                     beat;
    ARID    = recId[t];
    ARADDR  = recAddr[t];
    ARLEN   = recLen[t];
    ARSIZE  = recSize[t];
    ARBURST = axiBurstT'(recBurst[t]);
    ARVALID = 1'b1;
    hs = 1'b0;
    while (!hs) begin
      hs = ARREADY;
      nextCycle();
    end
    ARVALID = 1'b0;
    checks++;
    if (ARREADY) reportMismatch(t, "ARREADY still high after the AR handshake");
    a = recAddr[t][`MEM_ADDR_W-1:0];
    beat = 0;
    done = 1'b0;
    heldValid = 1'b0;
    heldData = '0;
    heldLast = 1'b0;
    while (!done) begin
      if (heldValid) begin
        checks++;
        if (!RVALID || RDATA !== heldData || RLAST !== heldLast) begin
          reportMismatch(t, "R beat changed while RREADY was low");
        end
      end
      takeBit(stall);
      RREADY    = !stall;
      heldValid = RVALID && !RREADY;
      heldData  = RDATA;
      heldLast  = RLAST;
      if (RVALID && RREADY) begin
        checks++;
        if (RID !== recId[t] || RRESP !== recResp[t]) begin
          reportMismatch(t, $sformatf("RID %h RRESP %0d, expected %h %0d",
                                      RID, RRESP, recId[t], recResp[t]));
        end
        checks++;
        if (RLAST !== (beat == recLen[t])) begin
          reportMismatch(t, $sformatf("RLAST %b on beat %0d of a %0d-beat burst",
                                      RLAST, beat, recLen[t] + 1));
        end
        checkWord(t, beat, a, RDATA);
        a = advanceAddr(a, recSize[t], recBurst[t]);
        beat++;
        done = RLAST || (beat > recLen[t]);
      end
      nextCycle();
    end
    RREADY = 1'b0;
    checks++;
    if (beat != recLen[t] + 1) begin
      reportMismatch(t, $sformatf("%0d R beats, expected %0d", beat, recLen[t] + 1));
    end
    checks++;
    if (RVALID) reportMismatch(t, "RVALID still high after the RLAST beat");
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    logic loaded;
    int   beatPos;
    ACLK    = 1'b0;
    ARESETn = 1'b0;
    AWID    = '0;
    AWADDR  = '0;
    AWLEN   = '0;
    AWSIZE  = '0;
    AWBURST = FIXED;
    AWVALID = 1'b0;
    WDATA   = '0;
    WSTRB   = '0;
    WLAST   = 1'b0;
    WVALID  = 1'b0;
    BREADY  = 1'b0;
    ARID    = '0;
    ARADDR  = '0;
    ARLEN   = '0;
    ARSIZE  = '0;
    ARBURST = FIXED;
    ARVALID = 1'b0;
    RREADY  = 1'b0;
    beatPos = 0;
    for (int i = 0; i < (1 << `MEM_ADDR_W); i++) refKnown[i] = 1'b0;
    loadStimulus(loaded);
    if (loaded) begin
      repeat (2) @(posedge ACLK);
      #1;
      ARESETn = 1'b1;
      for (int t = 0; t < recWrite.size(); t++) begin
        testErrors = 0;
        if (recWrite[t]) begin
          runWrite(t, beatPos);
        end else begin
          runRead(t);
        end
        $display("test %0d %s id %h addr %h len %0d: %s", t + 1,
                 recWrite[t] ? "write" : "read ", recId[t], recAddr[t], recLen[t],
                 (testErrors == 0) ? "ok" : "mismatch");
      end
    end
    $display("tests %0d, checks %0d, errors %0d", recWrite.size(), checks, errors);
    if (loaded && errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
logic/axiProtoPkg.sv
logic/memTypesPkg.sv
logic/memWriteIf.sv
logic/axiWriteCtrl.sv
logic/axiReadCtrl.sv
logic/memDualPortRam.sv
logic/memAxiTop.sv
testbench/tbMemAxi.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tbMemAxi -o simMemAxi
./obj_dir/simMemAxi | tee sim.log

if grep -q "All checks passed" sim.log; then
  echo "simulation PASSED"
else
  echo "simulation FAILED"
  exit 1
fi

// ==== testbench/memAxi_stimulus.txt ====
# record: W|R id addr len size burst dropWlast resp, hex; burst 0 FIXED 1 INCR, resp 0 OKAY 2 SLVERR
# each W record is followed by len+1 beat lines: wdata wstrb
W 3 00000100 00 2 1 0 0
a1b2c3d4 f
R 5 00000100 00 2 1 0 0
W 6 00000100 00 2 1 0 0
55667788 5
R 7 00000100 00 2 1 0 0
W 1 00000200 07 2 1 0 0
10203040 f
11213141 f
12223242 f
13233343 f
14243444 f
15253545 f
16263646 f
17273747 f
W 2 00000301 03 0 1 0 0
0000bb00 2
00cc0000 4
dd000000 8
000000ee 1
R 9 00001200 07 2 1 0 0
R a 00000301 03 0 1 0 0
W 4 00000400 01 2 0 0 0
12345678 f
9abcdef0 f
R b 00000400 02 2 0 0 0
W c 00000500 01 2 1 1 2
cafe0001 f
cafe0002 f
R d 00000500 01 2 1 0 0
